/* bus_defines.svh */
`ifndef BUS_DEFINES_SVH
`define BUS_DEFINES_SVH

// bus widths
`define BUS_ADDR_W      32
`define BUS_DATA_W      32
`define BUS_FIFO_DEPTH  4

// led slave window
`define LED_BASE_ADDR   32'h2000_0000
`define LED_END_ADDR    32'h2FFF_FFFF

`define LED_W           8
`define BTN_W           4

`endif

/* bus_pkg.sv */
`default_nettype none

`include "bus_defines.svh"

package bus_pkg;

    typedef logic [`BUS_ADDR_W-1:0]   addr_t;
    typedef logic [`BUS_DATA_W-1:0]   data_t;
    typedef logic [`BUS_DATA_W/8-1:0] strb_t;

    typedef enum logic [1:0] {
        OKAY   = 2'd0,
        DECERR = 2'd3
    } resp_t;

    // request source tag
    localparam logic SRC_HOST = 1'b0;
    localparam logic SRC_BTN  = 1'b1;

    typedef struct packed {
        addr_t addr;
        data_t data;
        strb_t strb;
        logic  src;
    } wr_req_t;

    typedef struct packed {
        resp_t resp;
        logic  src;     // routes the response back
    } wr_rsp_t;

endpackage

`default_nettype wire

/* board_pkg.sv */
`default_nettype none

`include "bus_defines.svh"

package board_pkg;

    typedef logic [`BTN_W-1:0] btn_t;
    typedef logic [`LED_W-1:0] led_t;

    typedef enum logic {
        IDLE = 1'b0,
        SEND = 1'b1     // request on the bus
    } btn_state_t;

endpackage

`default_nettype wire

/* btn_master.sv */
`default_nettype none
`timescale 1ns/1ps

`include "bus_defines.svh"

module btn_master (
    input  wire                    sys_clk,
    input  wire                    arst_n,
    input  wire board_pkg::btn_t   btn,
    output bus_pkg::wr_req_t       btn_req,
    output logic                   btn_valid,
    input  wire                    btn_ready
);
    import bus_pkg::*;
    import board_pkg::*;

    localparam int IDX_W = $clog2(`BTN_W);

    btn_t             btn_q;
    btn_t             rise;
    btn_t             pending;
    btn_t             waiting;
    btn_t             sent;
    btn_state_t       state;
    logic [IDX_W-1:0] sel_idx;
    logic             done;

    // lowest set bit wins
    function automatic logic [IDX_W-1:0] lowest_set(input btn_t v);
        logic [IDX_W-1:0] idx;
        idx = '0;
        for (int i = `BTN_W - 1; i >= 0; i--) begin
            if (v[i]) begin
                idx = IDX_W'(i);
            end
        end
        return idx;
    endfunction

    assign rise    = btn & ~btn_q;
    assign waiting = pending | rise;   // a press seen this cycle counts too
    assign done    = btn_valid & btn_ready;
    assign sent    = done ? (btn_t'(1) << sel_idx) : '0;

    assign btn_valid = (state == SEND);
    assign btn_req   = '{addr: addr_t'(`LED_BASE_ADDR),
                         data: data_t'(1) << sel_idx,
                         strb: strb_t'(1),
                         src:  SRC_BTN};

    always_ff @(posedge sys_clk or negedge arst_n) begin
        if (!arst_n) begin
            btn_q   <= '0;
            pending <= '0;
            sel_idx <= '0;
            state   <= IDLE;
        end else begin
            btn_q   <= btn;
            pending <= waiting & ~sent;
            case (state)
                IDLE: begin
                    if (waiting != '0) begin
                        sel_idx <= lowest_set(waiting);
                        state   <= SEND;
                    end
                end
                SEND: begin
                    if (done) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

/* wr_arbiter.sv */
`default_nettype none
`timescale 1ns/1ps

module wr_arbiter (
    input  wire                    sys_clk,
    input  wire                    arst_n,
    // host write port
    input  wire bus_pkg::addr_t    awaddr,
    input  wire                    awvalid,
    output logic                   awready,
    input  wire bus_pkg::data_t    wdata,
    input  wire bus_pkg::strb_t    wstrb,
    input  wire                    wvalid,
    output logic                   wready,
    output bus_pkg::resp_t         bresp,
    output logic                   bvalid,
    input  wire                    bready,
    // button master
    input  wire bus_pkg::wr_req_t  btn_req,
    input  wire                    btn_valid,
    output logic                   btn_ready,
    // request FIFO
    output bus_pkg::wr_req_t       push_req,
    output logic                   push_valid,
    input  wire                    push_ready,
    // slave responses
    input  wire bus_pkg::wr_rsp_t  rsp,
    input  wire                    rsp_valid,
    output logic                   rsp_ready
);
    import bus_pkg::*;

    wr_req_t host_req;
    logic    host_go;
    logic    b_load;

    // AW and W are taken together
    assign host_go  = awvalid & wvalid;
    assign host_req = '{addr: awaddr, data: wdata, strb: wstrb, src: SRC_HOST};

    assign awready   = host_go & push_ready;
    assign wready    = host_go & push_ready;
    assign btn_ready = ~host_go & push_ready;   // host has fixed priority

    assign push_valid = host_go | btn_valid;
    assign push_req   = host_go ? host_req : btn_req;

    // button responses are dropped at once
    assign rsp_ready = (rsp.src == SRC_BTN) | bready;
    assign b_load    = rsp_valid & rsp_ready & (rsp.src == SRC_HOST);

    always_ff @(posedge sys_clk or negedge arst_n) begin
        if (!arst_n) begin
            bvalid <= 1'b0;
        end else if (b_load) begin
            bvalid <= 1'b1;
        end else if (bready) begin
            bvalid <= 1'b0;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (b_load) begin
            bresp <= rsp.resp;
        end
    end

endmodule

`default_nettype wire

/* wr_fifo.sv */
`default_nettype none
`timescale 1ns/1ps

`include "bus_defines.svh"

module wr_fifo #(
    parameter int DEPTH = `BUS_FIFO_DEPTH   // power of two
) (
    input  wire                    sys_clk,
    input  wire                    arst_n,
    input  wire bus_pkg::wr_req_t  push_req,
    input  wire                    push_valid,
    output logic                   push_ready,
    output bus_pkg::wr_req_t       pop_req,
    output logic                   pop_valid,
    input  wire                    pop_ready
);
    import bus_pkg::*;

    localparam int              PTR_W    = $clog2(DEPTH);
    localparam logic [PTR_W:0]  FULL_CNT = (PTR_W + 1)'(DEPTH);

    wr_req_t          mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             do_push;
    logic             do_pop;

    assign push_ready = (count != FULL_CNT);
    assign pop_valid  = (count != '0);
    assign pop_req    = mem[rd_ptr];

    assign do_push = push_valid & push_ready;
    assign do_pop  = pop_valid & pop_ready;

    always_ff @(posedge sys_clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_req;
        end
    end

    // pointers wrap on their own
    always_ff @(posedge sys_clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (!do_push && do_pop) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* led_slave.sv */
`default_nettype none
`timescale 1ns/1ps

`include "bus_defines.svh"

module led_slave (
    input  wire                    sys_clk,
    input  wire                    arst_n,
    input  wire bus_pkg::wr_req_t  pop_req,
    input  wire                    pop_valid,
    output logic                   pop_ready,
    output bus_pkg::wr_rsp_t       rsp,
    output logic                   rsp_valid,
    input  wire                    rsp_ready,
    output board_pkg::led_t        led
);
    import bus_pkg::*;

    logic in_window;
    logic take;

    // address decode
    assign in_window = (pop_req.addr >= addr_t'(`LED_BASE_ADDR)) &&
                       (pop_req.addr <= addr_t'(`LED_END_ADDR));

    // one request per cycle while the response slot frees up
    assign pop_ready = ~rsp_valid | rsp_ready;
    assign take      = pop_valid & pop_ready;

    always_ff @(posedge sys_clk or negedge arst_n) begin
        if (!arst_n) begin
            rsp_valid <= 1'b0;
        end else if (take) begin
            rsp_valid <= 1'b1;
        end else if (rsp_ready) begin
            rsp_valid <= 1'b0;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (take) begin
            rsp.resp <= in_window ? OKAY : DECERR;
            rsp.src  <= pop_req.src;
        end
    end

    // only byte lane 0 reaches the leds
    always_ff @(posedge sys_clk or negedge arst_n) begin
        if (!arst_n) begin
            led <= '0;
        end else if (take && in_window && pop_req.strb[0]) begin
            led <= pop_req.data[`LED_W-1:0];
        end
    end

endmodule

`default_nettype wire

/* axi_led_top.sv */
`default_nettype none
`timescale 1ns/1ps

`include "bus_defines.svh"

module axi_led_top (
    input  wire                   sys_clk,
    input  wire                   arst_n,
    input  wire board_pkg::btn_t  btn,
    output board_pkg::led_t       led,
    // host AXI4-Lite write channels
    input  wire bus_pkg::addr_t   awaddr,
    input  wire                   awvalid,
    output logic                  awready,
    input  wire bus_pkg::data_t   wdata,
    input  wire bus_pkg::strb_t   wstrb,
    input  wire                   wvalid,
    output logic                  wready,
    output bus_pkg::resp_t        bresp,
    output logic                  bvalid,
    input  wire                   bready
);
    import bus_pkg::*;

    wr_req_t btn_req;
    logic    btn_valid;
    logic    btn_ready;
    wr_req_t push_req;
    logic    push_valid;
    logic    push_ready;
    wr_req_t pop_req;
    logic    pop_valid;
    logic    pop_ready;
    wr_rsp_t rsp;
    logic    rsp_valid;
    logic    rsp_ready;

    btn_master btn_master0 (
        .sys_clk   (sys_clk),
        .arst_n    (arst_n),
        .btn       (btn),
        .btn_req   (btn_req),
        .btn_valid (btn_valid),
        .btn_ready (btn_ready)
    );

    wr_arbiter wr_arbiter0 (
        .sys_clk    (sys_clk),
        .arst_n     (arst_n),
        .awaddr     (awaddr),
        .awvalid    (awvalid),
        .awready    (awready),
        .wdata      (wdata),
        .wstrb      (wstrb),
        .wvalid     (wvalid),
        .wready     (wready),
        .bresp      (bresp),
        .bvalid     (bvalid),
        .bready     (bready),
        .btn_req    (btn_req),
        .btn_valid  (btn_valid),
        .btn_ready  (btn_ready),
        .push_req   (push_req),
        .push_valid (push_valid),
        .push_ready (push_ready),
        .rsp        (rsp),
        .rsp_valid  (rsp_valid),
        .rsp_ready  (rsp_ready)
    );

    wr_fifo #(
        .DEPTH (`BUS_FIFO_DEPTH)
    ) wr_fifo0 (
        .sys_clk    (sys_clk),
        .arst_n     (arst_n),
        .push_req   (push_req),
        .push_valid (push_valid),
        .push_ready (push_ready),
        .pop_req    (pop_req),
        .pop_valid  (pop_valid),
        .pop_ready  (pop_ready)
    );

    led_slave led_slave0 (
        .sys_clk   (sys_clk),
        .arst_n    (arst_n),
        .pop_req   (pop_req),
        .pop_valid (pop_valid),
        .pop_ready (pop_ready),
        .rsp       (rsp),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .led       (led)
    );

endmodule

`default_nettype wire

/* tb_axi_led_top.sv */
`default_nettype none
`timescale 1ns/1ps

`include "bus_defines.svh"

module tb_axi_led_top;
    import bus_pkg::*;
    import board_pkg::*;

    localparam int TIMEOUT = 200;

    logic  sys_clk;
    logic  arst_n;
    btn_t  btn;
    led_t  led;
    addr_t awaddr;
    logic  awvalid;
    logic  awready;
    data_t wdata;
    strb_t wstrb;
    logic  wvalid;
    logic  wready;
    resp_t bresp;
    logic  bvalid;
    logic  bready;

    int   errors;
    int   checks;
    int   tests;
    int   seed;
    led_t exp_led;

    axi_led_top dut0 (
        .sys_clk (sys_clk),
        .arst_n  (arst_n),
        .btn     (btn),
        .led     (led),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready)
    );

    initial begin
        sys_clk = 1'b0;
        forever #50 sys_clk = ~sys_clk;
    end

    function automatic bit in_led_window(input addr_t a);
        return (a >= `LED_BASE_ADDR) && (a <= `LED_END_ADDR);
    endfunction

    function automatic resp_t expected_resp(input addr_t a);
        if (in_led_window(a)) begin
            return OKAY;
        end
        return DECERR;
    endfunction

    // byte lane 0 lands on the leds
    function automatic led_t expected_led(input led_t cur, input addr_t a, input data_t d,
                                          input strb_t s);
        if (in_led_window(a) && s[0]) begin
            return d[`LED_W-1:0];
        end
        return cur;
    endfunction

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests++;
        if (errors == errs_before) begin
            $display("%-24s ok", name);
        end else begin
            $display("%-24s %0d error(s)", name, errors - errs_before);
        end
    endtask

    // AW/W stay valid until the accepting edge
    task automatic offer_write(input addr_t a, input data_t d, input strb_t s);
        int n;
        n = 0;
        @(posedge sys_clk);
        awaddr  <= a;
        wdata   <= d;
        wstrb   <= s;
        awvalid <= 1'b1;
        wvalid  <= 1'b1;
        @(negedge sys_clk);
        while (!(awready && wready) && n < TIMEOUT) begin
            @(negedge sys_clk);
            n++;
        end
        if (!(awready && wready)) begin
            $display("write to 0x%08h was never accepted", a);
            errors++;
        end
    endtask

    task automatic idle_bus;
        @(posedge sys_clk);
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
    endtask

    task automatic host_write(input addr_t a, input data_t d, input strb_t s);
        int n;
        n = 0;
        offer_write(a, d, s);
        idle_bus();
        @(negedge sys_clk);
        while (!bvalid && n < TIMEOUT) begin
            @(negedge sys_clk);
            n++;
        end
        if (!bvalid) begin
            $display("no write response for address 0x%08h", a);
            errors++;
        end else begin
            exp_led = expected_led(exp_led, a, d, s);
            check_val("bresp", 32'(bresp), 32'(expected_resp(a)));
            check_val("led", 32'(led), 32'(exp_led));
        end
        @(posedge sys_clk);   // B handshake
    endtask

    task automatic reset_values;
        int e0;
        e0 = errors;
        @(negedge sys_clk);
        check_val("led", 32'(led), 32'h0);
        check_val("bvalid", 32'(bvalid), 32'h0);
        check_val("awready", 32'(awready), 32'h0);
        check_val("wready", 32'(wready), 32'h0);
        report_test("reset values", e0);
    endtask

    task automatic write_in_window;
        int e0;
        e0 = errors;
        host_write(32'h2000_0010, 32'h0000_00A5, 4'hF);
        report_test("host write in window", e0);
    endtask

    task automatic strobe_masking;
        int e0;
        e0 = errors;
        host_write(32'h2000_0020, 32'h0000_003C, 4'hE);   // lane 0 off
        host_write(32'h2000_0020, 32'h0000_003C, 4'h1);
        report_test("strobe masking", e0);
    endtask

    task automatic decode_errors;
        int e0;
        e0 = errors;
        host_write(32'h1000_0000, 32'h0000_0055, 4'hF);
        host_write(32'h3000_0000, 32'h0000_00FF, 4'hF);
        report_test("decode error", e0);
    endtask

    task automatic button_presses;
        int e0;
        int n;
        int b_seen;
        e0 = errors;
        for (int i = 0; i < `BTN_W; i++) begin
            n = 0;
            b_seen = 0;
            @(negedge sys_clk);
            while (dut0.btn_master0.state != IDLE && n < TIMEOUT) begin
                @(negedge sys_clk);
                n++;
            end
            @(posedge sys_clk);
            btn <= btn_t'(1) << i;
            repeat (3) @(posedge sys_clk);
            btn <= '0;
            exp_led = led_t'(1) << i;
            n = 0;
            @(negedge sys_clk);
            while (led !== exp_led && n < TIMEOUT) begin
                b_seen += int'(bvalid);
                @(negedge sys_clk);
                n++;
            end
            if (led !== exp_led) begin
                $display("led did not follow button %0d", i);
                errors++;
            end
            repeat (4) begin
                @(negedge sys_clk);
                b_seen += int'(bvalid);
            end
            check_val("b_seen", 32'(b_seen), 32'h0);
        end
        report_test("button press", e0);
    endtask

    task automatic back_pressure;
        int    e0;
        int    n;
        int    got;
        addr_t a;
        data_t d;
        led_t  first_led;
        addr_t a_q[$];
        e0 = errors;
        first_led = exp_led;
        @(posedge sys_clk);
        bready <= 1'b0;
        for (int k = 0; k < 5; k++) begin
            a = `LED_BASE_ADDR | (addr_t'($random(seed)) & 32'h0FFF_FFFC);
            d = data_t'($random(seed));
            a_q.push_back(a);
            exp_led = expected_led(exp_led, a, d, 4'hF);
            if (k == 0) begin
                first_led = exp_led;
            end
            offer_write(a, d, 4'hF);
        end
        // a sixth offer stalls once slave and FIFO are full
        @(posedge sys_clk);
        awaddr  <= `LED_BASE_ADDR;
        wdata   <= '0;
        awvalid <= 1'b1;
        wvalid  <= 1'b1;
        repeat (4) begin
            @(negedge sys_clk);
            check_val("awready", 32'(awready), 32'h0);
            check_val("wready", 32'(wready), 32'h0);
            check_val("bvalid", 32'(bvalid), 32'h0);
        end
        check_val("led", 32'(led), 32'(first_led));   // only the first write popped
        idle_bus();
        @(posedge sys_clk);
        bready <= 1'b1;
        got = 0;
        n = 0;
        while (got < 5 && n < TIMEOUT) begin
            @(negedge sys_clk);
            n++;
            if (bvalid) begin
                check_val("bresp", 32'(bresp), 32'(expected_resp(a_q[got])));
                got++;
            end
        end
        if (got != 5) begin
            $display("only %0d of 5 write responses arrived", got);
            errors++;
        end
        repeat (4) begin
            @(negedge sys_clk);
            if (bvalid) begin
                $display("an extra write response appeared");
                errors++;
            end
        end
        check_val("led", 32'(led), 32'(exp_led));
        report_test("back-pressure and order", e0);
    endtask

    initial begin
        errors  = 0;
        checks  = 0;
        tests   = 0;
        seed    = 26;
        exp_led = '0;
        arst_n  = 1'b0;
        btn     = '0;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        wvalid  = 1'b0;
        bready  = 1'b1;
        repeat (16) @(posedge sys_clk);
        arst_n <= 1'b1;

        reset_values();
        write_in_window();
        strobe_masking();
        decode_errors();
        button_presses();
        back_pressure();

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+.
bus_pkg.sv
board_pkg.sv
btn_master.sv
wr_arbiter.sv
wr_fifo.sv
led_slave.sv
axi_led_top.sv
tb_axi_led_top.sv

/* Makefile */
TOOL     := verilator
TOP      := tb_axi_led_top
FILELIST := vlog.f
FLAGS    := --binary --timing --timescale 1ns/1ps -j 0
OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
LOG      := sim.log
SRCS     := $(shell grep -v '^+' $(FILELIST)) $(wildcard *.svh)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "^Test passed$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
